// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_wifi_tx_puncture
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bit_fifo.sv
`timescale 1ns/1ps

module bit_fifo #(
	parameter int DEPTH = wifi_tx_pkg::DEF_FIFO_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic we,
	input logic wr_bit,
	input logic re,
	output logic rd_bit,
	output logic rd_valid
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// Occupancy.
	logic [CW-1:0] count;

	// Pointer advance with wrap at DEPTH.
	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ====================
	// Pointers and count.
	// ====================

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			if (we)
				wr_ptr <= ptr_next(wr_ptr);
			if (re)
				rd_ptr <= ptr_next(rd_ptr);
			if (we && !re)
				count <= count + 1'b1;
			else if (re && !we)
				count <= count - 1'b1;
			// Read data lands one cycle after re.
			rd_valid <= re;
		end
	end

	// Storage and registered read port.
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_ptr] <= wr_bit;
		if (re)
			rd_bit <= mem[rd_ptr];
	end

	a_no_overflow : assert property (@(posedge clk) disable iff (!reset)
		we |-> (count != CW'(DEPTH)));
	a_no_underflow : assert property (@(posedge clk) disable iff (!reset)
		re |-> (count != '0));

endmodule

// File: files.f
wifi_tx_pkg.sv
tx_scrambler.sv
puncture_control.sv
bit_fifo.sv
puncture_lane.sv
symbol_packer.sv
wifi_tx_puncture_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_wifi_tx_puncture.sv

// File: puncture_control.sv
`timescale 1ns/1ps

module puncture_control #(
	parameter int HEADER_BITS = wifi_tx_pkg::DEF_HEADER_BITS
) (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic data_in,
	output logic we,
	output logic re,
	output logic data_out
);

	import wifi_tx_pkg::*;

	// Bits written to the FIFO this frame.
	count_t kept_cnt;
	// Remaining reads in the burst.
	count_t out_cnt;
	// Position inside the group of six.
	pat_t pat_cnt;
	logic in_header;
	logic drop_pos;
	logic keep;

	// ====================
	// Keep or drop decision.
	// ====================

	// Header length counts kept bits, all of them kept there.
	assign in_header = (kept_cnt < count_t'(HEADER_BITS));
	assign drop_pos = (pat_cnt == pat_t'(PUNCT_DROP_FIRST)) ||
		(pat_cnt == pat_t'(PUNCT_DROP_SECOND));
	assign keep = valid_in && (in_header || !drop_pos);

	// ====================
	// Counters and strobes.
	// ====================

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			we <= 1'b0;
			re <= 1'b0;
			kept_cnt <= '0;
			out_cnt <= '0;
			pat_cnt <= '0;
		end
		else if (valid_in)
		begin
			// Dropped bits leave we low.
			we <= keep;
			re <= 1'b0;
			if (keep)
				kept_cnt <= kept_cnt + 1'b1;
			// Pattern steps only after the header.
			if (!in_header)
			begin
				if (pat_cnt == pat_t'(PUNCT_PERIOD - 1))
					pat_cnt <= '0;
				else
					pat_cnt <= pat_cnt + 1'b1;
			end
		end
		else
		begin
			we <= 1'b0;
			// Next frame restarts the pattern.
			pat_cnt <= '0;
			if (out_cnt == '0)
			begin
				// First idle cycle loads the burst length.
				out_cnt <= kept_cnt;
				re <= 1'b0;
			end
			else
			begin
				// One read per cycle.
				kept_cnt <= '0;
				out_cnt <= out_cnt - 1'b1;
				re <= 1'b1;
			end
		end
	end

	// Bit that goes with the write strobe.
	always_ff @(posedge clk)
	begin
		if (keep)
			data_out <= data_in;
	end

	// Readout burst must end before the next frame arrives.
	a_no_read_in_frame : assert property (@(posedge clk) disable iff (!reset)
		!(re && valid_in));

endmodule

// File: puncture_lane.sv
`timescale 1ns/1ps

module puncture_lane #(
	parameter int HEADER_BITS = wifi_tx_pkg::DEF_HEADER_BITS,
	parameter int FIFO_DEPTH = wifi_tx_pkg::DEF_FIFO_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic data_in,
	output logic rd_valid,
	output logic rd_bit
);

	// Write strobe and kept bit toward the FIFO.
	logic lane_we;
	logic lane_bit;
	// Burst read strobe.
	logic lane_re;

	// ====================
	// Puncture controller.
	// ====================

	puncture_control #(
		.HEADER_BITS(HEADER_BITS)
	) i_puncture_control (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.data_in(data_in),
		.we(lane_we),
		.re(lane_re),
		.data_out(lane_bit)
	);

	// ====================
	// Kept-bit store.
	// ====================

	// Holds a whole frame until the burst.
	bit_fifo #(
		.DEPTH(FIFO_DEPTH)
	) i_bit_fifo (
		.clk(clk),
		.reset(reset),
		.we(lane_we),
		.wr_bit(lane_bit),
		.re(lane_re),
		.rd_bit(rd_bit),
		.rd_valid(rd_valid)
	);

endmodule

// File: symbol_packer.sv
`timescale 1ns/1ps

module symbol_packer #(
	parameter int LANES = wifi_tx_pkg::DEF_LANES
) (
	input logic clk,
	input logic reset,
	input logic [LANES-1:0] rd_valid,
	input logic [LANES-1:0] rd_bit,
	output logic out_valid,
	output logic out_last,
	output logic [LANES*wifi_tx_pkg::BYTE_W-1:0] out_data
);

	import wifi_tx_pkg::*;

	localparam int CNT_W = $clog2(BYTE_W);

	// Lanes run in lockstep, lane 0 stands for all.
	logic bit_valid;
	logic bit_valid_d;
	logic frame_end;
	// Bits in the byte under construction, shared by all lanes.
	logic [CNT_W-1:0] bit_cnt;
	// A full byte waits for the next bit or the frame end.
	logic pending;
	logic [BYTE_W-1:0] shreg [LANES];
	logic [LANES*BYTE_W-1:0] held;
	logic send_full;

	assign bit_valid = rd_valid[0];
	assign frame_end = bit_valid_d & ~bit_valid;
	// Held byte goes out when the next bit shows up.
	assign send_full = bit_valid & pending;

	// Lane 0 in the lowest byte.
	for (genvar l = 0; l < LANES; l++)
	begin : g_flat
		assign held[l*BYTE_W +: BYTE_W] = shreg[l];
	end

	// ====================
	// Byte framing control.
	// ====================

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_valid_d <= 1'b0;
			bit_cnt <= '0;
			pending <= 1'b0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end
		else
		begin
			bit_valid_d <= bit_valid;
			if (bit_valid)
			begin
				out_valid <= pending;
				out_last <= 1'b0;
				// Wraps to zero after the eighth bit.
				bit_cnt <= bit_cnt + 1'b1;
				pending <= (bit_cnt == CNT_W'(BYTE_W - 1));
			end
			else if (frame_end)
			begin
				// Flush of a full or partial byte.
				out_valid <= 1'b1;
				out_last <= 1'b1;
				bit_cnt <= '0;
				pending <= 1'b0;
			end
			else
			begin
				out_valid <= 1'b0;
				out_last <= 1'b0;
			end
		end
	end

	// Bit k of a byte lands at position k.
	always_ff @(posedge clk)
	begin
		if (send_full || frame_end)
			out_data <= held;
		if (bit_valid)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				// New byte clears upper bits, giving zero padding.
				if (bit_cnt == '0)
					shreg[l] <= BYTE_W'(rd_bit[l]);
				else
					shreg[l][bit_cnt] <= rd_bit[l];
			end
		end
	end

	// Every lane keeps the same count, so reads stay aligned.
	a_lanes_aligned : assert property (@(posedge clk) disable iff (!reset)
		rd_valid == {LANES{rd_valid[0]}});

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
	parameter int LANES = wifi_tx_pkg::DEF_LANES,
	parameter int HEADER_BITS = wifi_tx_pkg::DEF_HEADER_BITS
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [LANES-1:0] in_data,
	input wifi_tx_pkg::scr_state_t seed,
	input logic out_valid,
	input logic [LANES*wifi_tx_pkg::BYTE_W-1:0] out_data,
	input logic out_last,
	output int mismatch_count,
	output int other_count,
	output int pending_count,
	output int checked_count
);

	import wifi_tx_pkg::*;

	// Frame as seen at the DUT pins.
	logic [LANES-1:0] frame_bits [$];
	scr_state_t frame_seed;
	logic in_valid_d = 1'b0;
	// Expected bytes in output order.
	logic [LANES*BYTE_W-1:0] exp_data_q [$];
	logic exp_last_q [$];
	int mismatches = 0;
	int others = 0;
	int checked = 0;
	// Expected bytes still waiting for the DUT.
	int pending_bytes = 0;

	assign mismatch_count = mismatches;
	assign other_count = others;
	assign pending_count = pending_bytes;
	assign checked_count = checked;

	// ====================
	// Reference model.
	// ====================

	// Header bits pass and positions 3 and 4 of each later six drop.
	function automatic bit bit_kept(input int idx);
		int pos;
		if (idx < HEADER_BITS)
			return 1'b1;
		pos = (idx - HEADER_BITS) % PUNCT_PERIOD;
		return (pos != PUNCT_DROP_FIRST) && (pos != PUNCT_DROP_SECOND);
	endfunction

	function automatic int kept_count(input int len);
		int k;
		k = 0;
		for (int i = 0; i < len; i++)
			if (bit_kept(i))
				k++;
		return k;
	endfunction

	// Byte idx of one lane in LSB first order with zero padding.
	function automatic logic [7:0] ref_byte(input int lane, input int idx);
		scr_state_t st;
		logic fb;
		logic sb;
		logic [7:0] result;
		int k;
		st = frame_seed;
		// Lane l starts from the seed rotated left by l.
		for (int r = 0; r < lane % SCR_W; r++)
			st = {st[SCR_W-2:0], st[SCR_W-1]};
		result = '0;
		k = 0;
		for (int i = 0; i < frame_bits.size(); i++)
		begin
			fb = st[6] ^ st[3];
			sb = frame_bits[i][lane] ^ fb;
			st = {st[SCR_W-2:0], fb};
			if (bit_kept(i))
			begin
				if (k / 8 == idx)
					result[k % 8] = sb;
				k++;
			end
		end
		return result;
	endfunction

	// Turns the finished frame into expected output words.
	task automatic queue_frame();
		int nbytes;
		logic [LANES*BYTE_W-1:0] word;
		nbytes = (kept_count(frame_bits.size()) + 7) / 8;
		for (int b = 0; b < nbytes; b++)
		begin
			for (int l = 0; l < LANES; l++)
				word[l*BYTE_W +: BYTE_W] = ref_byte(l, b);
			exp_data_q.push_back(word);
			// Only the final byte carries out_last.
			exp_last_q.push_back(b == nbytes - 1);
		end
	endtask

	// ====================
	// Output comparison.
	// ====================

	task automatic check_output();
		logic [LANES*BYTE_W-1:0] exp_data;
		logic exp_last;
		if (out_last && !out_valid)
		begin
			others++;
			$display("Error at %0t: out_last is high without out_valid", $time);
		end
		if (out_valid)
		begin
			if (exp_data_q.size() == 0)
			begin
				// Also catches output before the first readout.
				others++;
				$display("Error at %0t: extra byte %h when none was expected",
					$time, out_data);
			end
			else
			begin
				exp_data = exp_data_q.pop_front();
				exp_last = exp_last_q.pop_front();
				checked++;
				if (out_data !== exp_data)
				begin
					mismatches++;
					$display("MISMATCH at %0t: out_data expected %h got %h",
						$time, exp_data, out_data);
				end
				if (out_last !== exp_last)
				begin
					mismatches++;
					$display("MISMATCH at %0t: out_last expected %b got %b",
						$time, exp_last, out_last);
				end
			end
		end
	endtask

	// Sampled on the falling edge where inputs and outputs are settled.
	always @(negedge clk)
	begin
		if (reset)
		begin
			if (in_valid)
			begin
				if (!in_valid_d)
				begin
					frame_bits.delete();
					frame_seed = seed;
				end
				frame_bits.push_back(in_data);
			end
			else if (in_valid_d)
				queue_frame();
			in_valid_d = in_valid;
			check_output();
			pending_bytes = exp_data_q.size();
		end
	end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	// Free running clock.
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Active low reset, released on a rising edge.
	initial
	begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

// File: tb_wifi_tx_puncture.sv
`timescale 1ns/1ps

module tb_wifi_tx_puncture;

	import wifi_tx_pkg::*;

	localparam int LANES = 4;
	localparam int HEADER_BITS = 48;
	localparam int FIFO_DEPTH = 1024;
	localparam int CLK_NS = 10;
	localparam int N_DIRECTED = 10;
	localparam int N_FRAMES = 24;
	localparam logic [31:0] RAND_SEED = 32'h63b0_23aa;

	logic clk;
	logic reset;
	logic in_valid;
	logic [LANES-1:0] in_data;
	scr_state_t seed;
	logic out_valid;
	logic [LANES*BYTE_W-1:0] out_data;
	logic out_last;
	int mismatches;
	int other_errors;
	int pending;
	int checked;

	// Short, header edge, pattern edge and byte-multiple lengths.
	int directed_len [N_DIRECTED] = '{1, 7, 8, 47, 48, 49, 52, 53, 60, 101};
	int frame_len [N_FRAMES];
	int frame_gap [N_FRAMES];
	scr_state_t frame_seed [N_FRAMES];
	int limit_ns = 0;

	tb_clock_gen #(
		.PERIOD_NS(CLK_NS),
		.RESET_CYCLES(2)
	) i_tb_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	wifi_tx_puncture_top #(
		.LANES(LANES),
		.HEADER_BITS(HEADER_BITS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_wifi_tx_puncture_top (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.seed(seed),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last)
	);

	tb_checker #(
		.LANES(LANES),
		.HEADER_BITS(HEADER_BITS)
	) i_tb_checker (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.seed(seed),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last),
		.mismatch_count(mismatches),
		.other_count(other_errors),
		.pending_count(pending),
		.checked_count(checked)
	);

	// ====================
	// Frame stimulus.
	// ====================

	task automatic send_frame(input int f);
		repeat (frame_gap[f]) @(posedge clk);
		for (int i = 0; i < frame_len[f]; i++)
		begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_data <= LANES'($urandom);
			seed <= frame_seed[f];
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_data <= '0;
		// Next frame only after the last byte is out.
		do
			@(negedge clk);
		while (!out_last);
	endtask

	initial
	begin
		int total_cycles;
		int total_other;
		in_valid = 1'b0;
		in_data = '0;
		seed = '0;
		void'($urandom(RAND_SEED));
		total_cycles = 20;
		for (int f = 0; f < N_FRAMES; f++)
		begin
			if (f < N_DIRECTED)
				frame_len[f] = directed_len[f];
			else
				frame_len[f] = 1 + int'($urandom % 300);
			frame_gap[f] = int'($urandom % 6);
			frame_seed[f] = scr_state_t'(1 + $urandom % 127);
			// Input, readout and packing per frame.
			total_cycles += frame_gap[f] + 2 * frame_len[f] + 16;
		end
		// Extreme seeds.
		frame_seed[0] = 7'h01;
		frame_seed[1] = 7'h7f;
		limit_ns = 2 * total_cycles * CLK_NS;
		wait (reset);
		// Idle stretch, outputs must stay quiet here.
		repeat (5) @(posedge clk);
		for (int f = 0; f < N_FRAMES; f++)
			send_frame(f);
		repeat (4) @(posedge clk);
		total_other = other_errors;
		if (pending != 0)
		begin
			$display("Error: %0d expected bytes never appeared", pending);
			total_other = total_other + 1;
		end
		$display("Bytes checked: %0d, mismatches: %0d, other errors: %0d",
			checked, mismatches, total_other);
		if (mismatches == 0 && total_other == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog, armed once the frame list is known.
	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout: run still busy after %0d ns, a frame never finished", limit_ns);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: tx_scrambler.sv
`timescale 1ns/1ps

module tx_scrambler #(
	parameter int LANES = wifi_tx_pkg::DEF_LANES
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [LANES-1:0] in_data,
	input wifi_tx_pkg::scr_state_t seed,
	output logic scr_valid,
	output logic [LANES-1:0] scr_data
);

	import wifi_tx_pkg::*;

	// First cycle of a frame.
	logic frame_start;
	// Seed twice, so a slice gives any rotation.
	logic [2*SCR_W-1:0] seed_dup;
	scr_state_t state [LANES];
	// State used for the current bit.
	scr_state_t cur_state [LANES];
	logic [LANES-1:0] fb;
	logic [LANES-1:0] scr_bit;

	// scr_valid doubles as the delayed in_valid.
	assign frame_start = in_valid & ~scr_valid;
	assign seed_dup = {seed, seed};

	// ====================
	// Per-lane feedback.
	// ====================

	for (genvar l = 0; l < LANES; l++)
	begin : g_lane
		// Lane l starts from seed rotated left by l.
		localparam int ROT = l % SCR_W;

		assign cur_state[l] = frame_start ? seed_dup[2*SCR_W-1-ROT -: SCR_W] : state[l];
		assign fb[l] = cur_state[l][SCR_TAP_HI] ^ cur_state[l][SCR_TAP_LO];
		assign scr_bit[l] = in_data[l] ^ fb[l];
	end

	// Valid level, one cycle behind the input.
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			scr_valid <= 1'b0;
		else
			scr_valid <= in_valid;
	end

	// State shifts left with feedback into bit 0.
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			for (int l = 0; l < LANES; l++)
				state[l] <= {cur_state[l][SCR_W-2:0], fb[l]};
			scr_data <= scr_bit;
		end
	end

	// An all-zero seed would leave the scrambler stuck.
	a_seed_nonzero : assert property (@(posedge clk) disable iff (!reset)
		frame_start |-> (seed != '0));

endmodule

// File: wifi_tx_pkg.sv
package wifi_tx_pkg;

	// ====================
	// Default build values.
	// ====================

	// Spatial lanes running in lockstep.
	localparam int DEF_LANES = 4;
	// Rate-1/2 header bits that bypass puncturing.
	localparam int DEF_HEADER_BITS = 48;
	// Bits held per lane FIFO.
	localparam int DEF_FIFO_DEPTH = 1024;

	// ====================
	// Rate-3/4 drop pattern.
	// ====================

	localparam int PUNCT_PERIOD = 6;
	// Fourth and fifth bit of every group of six.
	localparam int PUNCT_DROP_FIRST = 3;
	localparam int PUNCT_DROP_SECOND = 4;
	localparam int PAT_W = $clog2(PUNCT_PERIOD);

	// ====================
	// Scrambler and byte packing.
	// ====================

	// Polynomial x^7 + x^4 + 1.
	localparam int SCR_W = 7;
	localparam int SCR_TAP_HI = 6;
	localparam int SCR_TAP_LO = 3;
	localparam int BYTE_W = 8;

	typedef logic [15:0] count_t;
	typedef logic [SCR_W-1:0] scr_state_t;
	typedef logic [PAT_W-1:0] pat_t;

endpackage

// File: wifi_tx_puncture_top.sv
`timescale 1ns/1ps

module wifi_tx_puncture_top #(
	parameter int LANES = wifi_tx_pkg::DEF_LANES,
	parameter int HEADER_BITS = wifi_tx_pkg::DEF_HEADER_BITS,
	parameter int FIFO_DEPTH = wifi_tx_pkg::DEF_FIFO_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [LANES-1:0] in_data,
	input wifi_tx_pkg::scr_state_t seed,
	output logic out_valid,
	output logic [LANES*wifi_tx_pkg::BYTE_W-1:0] out_data,
	output logic out_last
);

	// Whitened bits, one per lane.
	logic scr_valid;
	logic [LANES-1:0] scr_data;
	// FIFO readout of every lane.
	logic [LANES-1:0] lane_rd_valid;
	logic [LANES-1:0] lane_rd_bit;

	// ====================
	// Scrambler.
	// ====================

	tx_scrambler #(
		.LANES(LANES)
	) i_tx_scrambler (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.seed(seed),
		.scr_valid(scr_valid),
		.scr_data(scr_data)
	);

	// ====================
	// Puncture lanes.
	// ====================

	for (genvar l = 0; l < LANES; l++)
	begin : g_lane
		puncture_lane #(
			.HEADER_BITS(HEADER_BITS),
			.FIFO_DEPTH(FIFO_DEPTH)
		) i_puncture_lane (
			.clk(clk),
			.reset(reset),
			.valid_in(scr_valid),
			.data_in(scr_data[l]),
			.rd_valid(lane_rd_valid[l]),
			.rd_bit(lane_rd_bit[l])
		);
	end

	// Bytes out, last one flagged.
	symbol_packer #(
		.LANES(LANES)
	) i_symbol_packer (
		.clk(clk),
		.reset(reset),
		.rd_valid(lane_rd_valid),
		.rd_bit(lane_rd_bit),
		.out_valid(out_valid),
		.out_last(out_last),
		.out_data(out_data)
	);

endmodule
